// ==== Bender.yml ====
package:
  name: rob_core

sources:
  - common/rob_pkg.sv
  - hw/rob_decode.sv
  - ro_buffer/ro_buffer.sv
  - hw/exec_unit.sv
  - hw/arch_regfile.sv
  - hw/rob_core_top.sv
  - target: simulation
    files:
      - dv/rob_core_tb.sv

// ==== common/rob_pkg.sv ====
package rob_pkg;

    // Buffer and datapath sizes
    localparam int unsigned rob_entries = 8;
    localparam int unsigned rob_tag_w   = 3;
    localparam int unsigned xlen        = 32;
    localparam int unsigned reg_w       = 5;

    // RV32I major opcodes
    localparam logic [6:0] opcode_op  = 7'b0110011;
    localparam logic [6:0] opcode_imm = 7'b0010011;

    // funct3 and funct7 values of the supported subset
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_alt     = 7'b0100000;

    typedef logic [rob_tag_w-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        op_none,
        op_add,
        op_sub,
        op_xor,
        op_addi,
        op_xori,
        op_slli
    } alu_op_e;

    typedef struct packed {
        logic [6:0]       funct7;
        logic [reg_w-1:0] rs2;
        logic [reg_w-1:0] rs1;
        logic [2:0]       funct3;
        logic [reg_w-1:0] rd;
        logic [6:0]       opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0]      imm12;
        logic [reg_w-1:0] rs1;
        logic [2:0]       funct3;
        logic [reg_w-1:0] rd;
        logic [6:0]       opcode;
    } instr_i_t;

    // Same 32-bit word, seen as R or I format
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        alu_op_e          op;
        logic [reg_w-1:0] rd;
        logic [xlen-1:0]  a;
        logic [xlen-1:0]  b;
        logic             long_lane;
    } issue_t;

    typedef struct packed {
        issue_t   iss;
        rob_tag_t tag;
    } exec_req_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } wb_t;

    typedef struct packed {
        logic             valid;
        logic [reg_w-1:0] rd;
        logic [xlen-1:0]  value;
        rob_tag_t         tag;
    } commit_t;

endpackage

// ==== dv/rob_core_tb.sv ====
`timescale 1ns/1ps

module rob_core_tb;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
        logic [2:0]  tag;
    } expect_t;

    localparam int wait_limit  = 50;
    localparam int drain_limit = 200;

    logic             clk;
    logic             rst_n;
    logic             flush;
    logic [31:0]      instr;
    logic             instr_valid;
    logic             instr_ready;
    rob_pkg::commit_t commit;

    // Sequential model state
    logic [31:0] spec_regs [32];
    logic [31:0] done_regs [32];
    expect_t     exp_q [$];
    // Buffer slots are handed out in order from zero after reset and flush
    logic [2:0]  next_tag;
    logic [31:0] rng_state;
    logic        took;
    int          value_errs;
    int          proto_errs;
    int          timeouts;
    bit          timed_out;

    rob_core_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .commit      (commit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // 0 illegal, 1 add, 2 sub, 3 xor, 4 addi, 5 xori, 6 slli
    function automatic int op_of(logic [31:0] w);
        if (w[6:0] == 7'b0110011) begin
            if (w[14:12] == 3'b000 && w[31:25] == 7'h00) return 1;
            if (w[14:12] == 3'b000 && w[31:25] == 7'h20) return 2;
            if (w[14:12] == 3'b100 && w[31:25] == 7'h00) return 3;
        end else if (w[6:0] == 7'b0010011) begin
            if (w[14:12] == 3'b000) return 4;
            if (w[14:12] == 3'b100) return 5;
            if (w[14:12] == 3'b001 && w[31:25] == 7'h00) return 6;
        end
        return 0;
    endfunction

    function automatic logic in_flight(logic [4:0] r);
        foreach (exp_q[k]) begin
            if (exp_q[k].rd == r) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Entry shown on the commit port has already left the buffer
    function automatic logic ready_model(logic [31:0] w);
        int   op;
        int   used;
        logic hazard;
        op     = op_of(w);
        used   = exp_q.size() - int'(commit.valid);
        hazard = (w[19:15] != 0 && in_flight(w[19:15]))
              || (op <= 3 && w[24:20] != 0 && in_flight(w[24:20]));
        return (op == 0) || (used < 8 && !hazard);
    endfunction

    function automatic expect_t model_result(logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        expect_t     e;
        a    = spec_regs[w[19:15]];
        b    = (op_of(w) <= 3) ? spec_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        e.rd = w[11:7];
        case (op_of(w))
            1, 4:    e.value = a + b;
            2:       e.value = a - b;
            3, 5:    e.value = a ^ b;
            default: e.value = a << w[24:20];
        endcase
        return e;
    endfunction

    function automatic logic [31:0] r_word(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                           int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(logic [11:0] imm, int rs1, logic [2:0] f3, int rd);
        return {imm, rs1[4:0], f3, rd[4:0], 7'b0010011};
    endfunction

    // Registers x0..x7 only, so hazards come often
    function automatic logic [31:0] rand_instr();
        logic [31:0] r;
        r = xorshift32();
        case (r[31:29])
            3'd0:    return r_word(7'h00, r[8:6], r[5:3], 3'b000, r[2:0]);
            3'd1:    return r_word(7'h20, r[8:6], r[5:3], 3'b000, r[2:0]);
            3'd2:    return r_word(7'h00, r[8:6], r[5:3], 3'b100, r[2:0]);
            3'd3:    return i_word(r[20:9], r[5:3], 3'b000, r[2:0]);
            3'd4:    return i_word(r[20:9], r[5:3], 3'b100, r[2:0]);
            3'd7:    return r[9] ? {r[31:7], 7'b0000011}
                                 : i_word({7'h01, r[13:9]}, r[5:3], 3'b001, r[2:0]);
            default: return i_word({7'h00, r[13:9]}, r[5:3], 3'b001, r[2:0]);
        endcase
    endfunction

    always @(posedge clk) begin
        expect_t e;
        took = 1'b0;
        if (rst_n) begin
            if (instr_valid) begin
                assert (instr_ready === ready_model(instr)) else begin
                    value_errs++;
                    $display("ERR %0t instr_ready exp %b got %b", $time,
                             ready_model(instr), instr_ready);
                end
            end
            if (commit.valid) begin
                if (exp_q.size() == 0) begin
                    proto_errs++;
                    $display("%0t: a commit to x%0d came with nothing left to retire",
                             $time, commit.rd);
                end else begin
                    e = exp_q.pop_front();
                    assert (commit.rd == e.rd) else begin
                        value_errs++;
                        $display("ERR %0t commit.rd exp %0d got %0d", $time, e.rd, commit.rd);
                    end
                    assert (commit.value === e.value) else begin
                        value_errs++;
                        $display("ERR %0t commit.value exp %h got %h", $time, e.value,
                                 commit.value);
                    end
                    assert (commit.tag === e.tag) else begin
                        value_errs++;
                        $display("ERR %0t commit.tag exp %0d got %0d", $time, e.tag,
                                 commit.tag);
                    end
                    if (e.rd != 0) done_regs[e.rd] = e.value;
                end
            end
            took = instr_valid && instr_ready;
            if (took && !flush && op_of(instr) != 0) begin
                e        = model_result(instr);
                e.tag    = next_tag;
                next_tag = next_tag + 3'd1;
                exp_q.push_back(e);
                if (e.rd != 0) spec_regs[e.rd] = e.value;
            end
            // Back to what was retired so far
            if (flush) begin
                exp_q.delete();
                spec_regs = done_regs;
                next_tag  = '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) flush |=> !commit.valid)
        else begin
            proto_errs++;
            $display("%0t: a commit appeared in the cycle after a flush", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) commit.valid |-> !$isunknown(commit))
        else begin
            proto_errs++;
            $display("%0t: commit carries unknown bits", $time);
        end

    // Out of reset the core takes words and reports nothing
    assert property (@(posedge clk) $rose(rst_n) |-> instr_ready && !commit.valid)
        else begin
            proto_errs++;
            $display("%0t: core not idle and ready after reset", $time);
        end

    task automatic send(input logic [31:0] word);
        int waited;
        if (timed_out) return;
        waited      = 0;
        instr       = word;
        instr_valid = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!took && waited < wait_limit);
        instr_valid = 1'b0;
        if (!took) begin
            timeouts++;
            timed_out = 1'b1;
            $display("%0t: word %h not accepted within %0d cycles", $time, word, wait_limit);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit && !timed_out) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 && !timed_out) begin
            timeouts++;
            timed_out = 1'b1;
            $display("%0t: %0d results never committed", $time, exp_q.size());
        end
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    initial begin
        int          k;
        logic [31:0] r;
        rng_state   = 32'hf10ba8fa;
        rst_n       = 1'b0;
        flush       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        took        = 1'b0;
        next_tag    = '0;
        value_errs  = 0;
        proto_errs  = 0;
        timeouts    = 0;
        timed_out   = 1'b0;
        for (k = 0; k < 32; k++) begin
            spec_regs[k] = '0;
            done_regs[k] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Known values in x1..x7
        for (k = 1; k < 8; k++) begin
            r = xorshift32();
            send(i_word(r[11:0], 0, 3'b000, k));
        end
        // Slow shift ahead of quick adds
        send(i_word(12'd5, 2, 3'b001, 1));
        send(r_word(7'h00, 5, 4, 3'b000, 3));
        send(r_word(7'h00, 5, 4, 3'b000, 6));
        send(r_word(7'h20, 5, 4, 3'b000, 7));
        for (k = 0; k < 8; k++) send(i_word(12'(k), 7, 3'b001, 1 + k % 6));
        // Dependent chain on x1
        for (k = 0; k < 4; k++) send(i_word(12'hfff, 1, 3'b000, 1));
        send(r_word(7'h00, 1, 1, 3'b100, 2));
        send(r_word(7'h20, 2, 1, 3'b000, 3));
        // Load opcode, then a shift with a bad upper field
        send({25'h0abcde, 7'b0000011});
        send(i_word(12'h025, 3, 3'b001, 4));
        send(r_word(7'h00, 4, 3, 3'b000, 5));
        drain();

        // Drop two shifts in flight
        send(i_word(12'd3, 5, 3'b001, 5));
        send(i_word(12'd1, 6, 3'b001, 6));
        pulse_flush();
        send(r_word(7'h00, 6, 5, 3'b000, 1));
        // x0 stays zero for the add that follows
        send(i_word(12'h009, 5, 3'b000, 0));
        send(r_word(7'h00, 0, 0, 3'b000, 2));
        drain();

        for (k = 0; k < 300 && !timed_out; k++) begin
            r = xorshift32();
            if (r[4:0] == 5'd0) begin
                pulse_flush();
            end else begin
                send(rand_instr());
            end
        end
        drain();
        repeat (4) @(negedge clk);

        $display("Checks done: %0d value errors, %0d protocol errors, %0d timeouts",
                 value_errs, proto_errs, timeouts);
        if (value_errs + proto_errs + timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== hw/arch_regfile.sv ====
`timescale 1ns/1ps

module arch_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    output logic [31:0]       rs1_val,
    output logic [31:0]       rs2_val,
    output logic              rs1_pending,
    output logic              rs2_pending,
    input  logic              alloc_valid,
    input  logic [4:0]        alloc_rd,
    input  rob_pkg::rob_tag_t alloc_tag,
    input  rob_pkg::commit_t  commit
);
    import rob_pkg::*;

    logic [xlen-1:0]     regs   [2**reg_w];
    rob_tag_t            writer [2**reg_w];
    logic [2**reg_w-1:0] pending;

    // x0 reads as zero whatever the array holds
    assign rs1_val     = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val     = (rs2 == '0) ? '0 : regs[rs2];
    assign rs1_pending = pending[rs1];
    assign rs2_pending = pending[rs2];

    always_ff @(posedge clk) begin
        if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.value;
        end
        if (alloc_valid) begin
            writer[alloc_rd] <= alloc_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            pending <= '0;
        end else begin
            // Older writer retiring must not clear a younger claim
            if (commit.valid && writer[commit.rd] == commit.tag) begin
                pending[commit.rd] <= 1'b0;
            end
            // New allocation to the same register wins
            if (alloc_valid && alloc_rd != '0) begin
                pending[alloc_rd] <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               req_valid,
    input  rob_pkg::exec_req_t req,
    output rob_pkg::wb_t       wb_short,
    output rob_pkg::wb_t       wb_long
);
    import rob_pkg::*;

    typedef struct packed {
        rob_tag_t        tag;
        logic [xlen-1:0] a;
        logic [4:0]      shamt;
    } shift_stage_t;

    logic            short_v;
    rob_tag_t        short_tag;
    logic [xlen-1:0] short_val;
    logic [xlen-1:0] short_result;

    // Shift lane, two carry stages then the result stage
    logic            s1_v;
    logic            s2_v;
    logic            long_v;
    shift_stage_t    s1;
    shift_stage_t    s2;
    rob_tag_t        long_tag;
    logic [xlen-1:0] long_val;

    always_comb begin
        case (req.iss.op)
            op_add, op_addi: short_result = req.iss.a + req.iss.b;
            op_sub:          short_result = req.iss.a - req.iss.b;
            op_xor, op_xori: short_result = req.iss.a ^ req.iss.b;
            default:         short_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            short_v <= 1'b0;
            s1_v    <= 1'b0;
            s2_v    <= 1'b0;
            long_v  <= 1'b0;
        end else begin
            short_v <= req_valid && !req.iss.long_lane;
            s1_v    <= req_valid && req.iss.long_lane;
            s2_v    <= s1_v;
            long_v  <= s2_v;
        end
    end

    always_ff @(posedge clk) begin
        short_tag <= req.tag;
        short_val <= short_result;
        s1        <= '{tag: req.tag, a: req.iss.a, shamt: req.iss.b[4:0]};
        s2        <= s1;
        long_tag  <= s2.tag;
        long_val  <= s2.a << s2.shamt;
    end

    assign wb_short = '{valid: short_v, tag: short_tag, value: short_val};
    assign wb_long  = '{valid: long_v, tag: long_tag, value: long_val};

    // Only SLLI goes down the shift lane
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (req.iss.long_lane == (req.iss.op == op_slli)));

    // Lanes may finish together, never for the same entry
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_short.valid && wb_long.valid |-> wb_short.tag != wb_long.tag);

endmodule

// ==== hw/rob_core_top.sv ====
`timescale 1ns/1ps

module rob_core_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  rob_pkg::instr_u  instr,
    input  logic             instr_valid,
    output logic             instr_ready,
    output rob_pkg::commit_t commit
);
    import rob_pkg::*;

    logic [reg_w-1:0] rs1;
    logic [reg_w-1:0] rs2;
    logic [xlen-1:0]  rs1_val;
    logic [xlen-1:0]  rs2_val;
    logic             rs1_pending;
    logic             rs2_pending;
    logic             rob_full;
    logic             issue_valid;
    issue_t           issue;
    rob_tag_t         alloc_tag;
    exec_req_t        exec_req;
    wb_t              wb_short;
    wb_t              wb_long;

    rob_decode i_decode (
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .rs1_pending (rs1_pending),
        .rs2_pending (rs2_pending),
        .rob_full    (rob_full),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    ro_buffer i_rob (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .full        (rob_full),
        .alloc_tag   (alloc_tag),
        .exec_req    (exec_req),
        .wb_short    (wb_short),
        .wb_long     (wb_long),
        .commit      (commit)
    );

    exec_unit i_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .req_valid (issue_valid),
        .req       (exec_req),
        .wb_short  (wb_short),
        .wb_long   (wb_long)
    );

    arch_regfile i_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .rs1_pending (rs1_pending),
        .rs2_pending (rs2_pending),
        .alloc_valid (issue_valid),
        .alloc_rd    (issue.rd),
        .alloc_tag   (alloc_tag),
        .commit      (commit)
    );

endmodule

// ==== hw/rob_decode.sv ====
`timescale 1ns/1ps

module rob_decode (
    input  rob_pkg::instr_u instr,
    input  logic            instr_valid,
    output logic            instr_ready,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    input  logic [31:0]     rs1_val,
    input  logic [31:0]     rs2_val,
    input  logic            rs1_pending,
    input  logic            rs2_pending,
    input  logic            rob_full,
    output logic            issue_valid,
    output rob_pkg::issue_t issue
);
    import rob_pkg::*;

    alu_op_e op;
    logic    is_r;
    logic    is_i;
    logic    legal;
    logic    hazard;

    assign is_r = (instr.r.opcode == opcode_op);
    assign is_i = (instr.i.opcode == opcode_imm);

    always_comb begin
        op = op_none;
        if (is_r) begin
            if (instr.r.funct3 == f3_add_sub && instr.r.funct7 == f7_base) begin
                op = op_add;
            end else if (instr.r.funct3 == f3_add_sub && instr.r.funct7 == f7_alt) begin
                op = op_sub;
            end else if (instr.r.funct3 == f3_xor && instr.r.funct7 == f7_base) begin
                op = op_xor;
            end
        end else if (is_i) begin
            case (instr.i.funct3)
                f3_add_sub: op = op_addi;
                f3_xor:     op = op_xori;
                // Upper immediate bits must be zero for a plain shift
                f3_sll:     op = (instr.i.imm12[11:5] == f7_base) ? op_slli : op_none;
                default:    op = op_none;
            endcase
        end
    end

    assign legal = (op != op_none);
    assign rs1   = instr.r.rs1;
    assign rs2   = instr.r.rs2;

    // In I format the rs2 field holds immediate bits
    // Reads of x0 never wait
    assign hazard = (rs1 != '0 && rs1_pending) || (is_r && rs2 != '0 && rs2_pending);

    // Illegal words are swallowed
    assign instr_ready = !legal || (!rob_full && !hazard);
    assign issue_valid = instr_valid && legal && !rob_full && !hazard;

    always_comb begin
        issue.op        = op;
        issue.rd        = instr.r.rd;
        issue.a         = rs1_val;
        issue.b         = is_r ? rs2_val : {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
        issue.long_lane = (op == op_slli);
    end

endmodule

// ==== ro_buffer/ro_buffer.sv ====
`timescale 1ns/1ps

module ro_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               issue_valid,
    input  rob_pkg::issue_t    issue,
    output logic               full,
    output rob_pkg::rob_tag_t  alloc_tag,
    output rob_pkg::exec_req_t exec_req,
    input  rob_pkg::wb_t       wb_short,
    input  rob_pkg::wb_t       wb_long,
    output rob_pkg::commit_t   commit
);
    import rob_pkg::*;

    logic [rob_entries-1:0] ent_valid;
    logic [rob_entries-1:0] ent_done;
    logic [reg_w-1:0]       ent_rd    [rob_entries];
    logic [xlen-1:0]        ent_value [rob_entries];

    rob_tag_t           head;
    rob_tag_t           tail;
    logic [rob_tag_w:0] count;
    logic               alloc;
    logic               retire;

    logic               commit_valid;
    logic [reg_w-1:0]   commit_rd;
    logic [xlen-1:0]    commit_value;
    rob_tag_t           commit_tag;

    assign full   = (count == rob_entries);
    assign alloc  = issue_valid && !full;
    assign retire = ent_valid[head] && ent_done[head];

    // New entry goes to execute in the same cycle it is allocated
    assign alloc_tag = tail;
    assign exec_req  = '{iss: issue, tag: tail};

    assign commit = '{valid: commit_valid, rd: commit_rd, value: commit_value, tag: commit_tag};

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ent_valid    <= '0;
            ent_done     <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (retire) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= 1'b0;
                tail            <= tail + 1'b1;
            end
            // Both lanes can complete in one cycle
            if (wb_short.valid) begin
                ent_done[wb_short.tag] <= 1'b1;
            end
            if (wb_long.valid) begin
                ent_done[wb_long.tag] <= 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_rd[tail] <= issue.rd;
        end
        if (wb_short.valid) begin
            ent_value[wb_short.tag] <= wb_short.value;
        end
        if (wb_long.valid) begin
            ent_value[wb_long.tag] <= wb_long.value;
        end
        commit_rd    <= ent_rd[head];
        commit_value <= ent_value[head];
        commit_tag   <= head;
    end

    // Decoder must never issue into a full buffer
    assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> !full);

    // Each result lands once, on a live entry
    assert property (@(posedge clk) disable iff (!rst_n || flush)
        wb_short.valid |-> ent_valid[wb_short.tag] && !ent_done[wb_short.tag]);
    assert property (@(posedge clk) disable iff (!rst_n || flush)
        wb_long.valid |-> ent_valid[wb_long.tag] && !ent_done[wb_long.tag]);

endmodule

// ==== src.f ====
common/rob_pkg.sv
hw/rob_decode.sv
ro_buffer/ro_buffer.sv
hw/exec_unit.sv
hw/arch_regfile.sv
hw/rob_core_top.sv
dv/rob_core_tb.sv
